// ==== dv/ramio_properties.sv ====
// --------------------------------------------------------------------------
// concurrent checks on the ramio client port, LEDs and UART words
// bound into ramio with a shadow RAM built from the client writes
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module ramio_properties
  import ramio_map_pkg::*;
  import ramio_uart_pkg::*;
(
  input logic              clk,
  input logic              rst_n,
  input logic              enable,
  input logic [addr_w-1:0] address,
  input read_type_t        read_type,
  input logic [1:0]        write_type,
  input logic [data_w-1:0] data_in,
  input logic [data_w-1:0] data_out,
  input logic              data_out_ready,
  input logic [3:0]        led,
  input logic              uart_tx,
  input logic              tx_busy
);

  logic [data_w-1:0] shadow [ram_words];
  logic [data_w-1:0] echo_word;
  logic              io_addr;
  logic              rd;
  logic              wr;
  logic              rd_led;
  logic              rd_tx;
  logic              rd_rx;
  logic              wr_tx;
  logic              wr_led;
  logic              ram_rd;
  // read by the testbench
  int                error_count = 0;

  assign io_addr = (address == addr_led) || (address == addr_uart_out) ||
                   (address == addr_uart_in);
  assign rd      = enable && (read_type.raw != 3'b000);
  assign wr      = enable && (write_type != 2'b00);
  assign rd_led  = rd && (address == addr_led);
  assign rd_tx   = rd && (address == addr_uart_out);
  assign rd_rx   = rd && (address == addr_uart_in);
  assign wr_tx   = wr && (address == addr_uart_out);
  assign wr_led  = wr && (address == addr_led);
  assign ram_rd  = rd && !io_addr;

  // lane select then sign or zero fill
  function automatic logic [data_w-1:0] expected_load(input logic [data_w-1:0] word,
                                                      input read_type_t rt,
                                                      input logic [1:0] off);
    logic [data_w-1:0] lanes;
    logic [data_w-1:0] value;
    lanes = word >> (8 * off);
    value = '0;
    if (rt.fields.size == size_word) begin
      value = word;
    end else if (rt.fields.size == size_byte) begin
      value = {24'h00_0000, lanes[7:0]};
      if (rt.fields.sign_ext && lanes[7]) begin
        value[31:8] = '1;
      end
    end else if (rt.fields.size == size_half && !off[0]) begin
      value = {16'h0000, lanes[15:0]};
      if (rt.fields.sign_ext && lanes[15]) begin
        value[31:16] = '1;
      end
    end
    return value;
  endfunction

  // --------------------------------------------------------------------------
  // reference state from the client port
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_n && wr && !io_addr) begin
      case (write_type)
        size_byte: shadow[address[7:2]][8 * address[1:0] +: 8] <= data_in[7:0];
        size_half: begin
          // odd offsets leave the word alone
          if (!address[0]) begin
            shadow[address[7:2]][16 * address[1] +: 16] <= data_in[15:0];
          end
        end
        default: shadow[address[7:2]] <= data_in;
      endcase
    end
  end

  // expected tx word and loopback echo
  // stays empty until the first send
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      echo_word <= uart_empty;
    end else if (wr_tx) begin
      echo_word <= {24'h00_0000, data_in[7:0]};
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) !rst_n |=> (led == 4'b1111) && uart_tx)
    else begin
      error_count++;
      $error("ERROR %0t led or uart_tx not at reset value", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   rd_led |-> data_out_ready && (data_out == '0))
    else begin
      error_count++;
      $error("ERROR %0t LED word read gave %h", $time, data_out);
    end

  // byte held from the write until the frame is off the line
  assert property (@(posedge clk) disable iff (!rst_n)
                   rd_tx && (tx_busy || $past(tx_busy) || $past(wr_tx)) |->
                   data_out_ready && (data_out == echo_word))
    else begin
      error_count++;
      $error("ERROR %0t tx word read gave %h while sending", $time, data_out);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   rd_tx && !tx_busy && !$past(tx_busy) && !$past(wr_tx) |->
                   data_out_ready && (data_out == uart_empty))
    else begin
      error_count++;
      $error("ERROR %0t idle tx word read gave %h", $time, data_out);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   rd_rx |-> data_out_ready &&
                   ((data_out == uart_empty) || (data_out == echo_word)))
    else begin
      error_count++;
      $error("ERROR %0t rx word read gave %h", $time, data_out);
    end

  // a read empties the receive word
  assert property (@(posedge clk) disable iff (!rst_n)
                   rd_rx && $past(rd_rx) && ($past(data_out) != uart_empty) |->
                   data_out == uart_empty)
    else begin
      error_count++;
      $error("ERROR %0t rx word not empty after read, got %h", $time, data_out);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   wr_led |=> led == $past(data_in[3:0]))
    else begin
      error_count++;
      $error("ERROR %0t led %b after LED write", $time, led);
    end

  assert property (@(posedge clk) disable iff (!rst_n) !wr_led |=> $stable(led))
    else begin
      error_count++;
      $error("ERROR %0t led changed without a write", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) ram_rd |=> data_out_ready)
    else begin
      error_count++;
      $error("ERROR %0t data_out_ready low after RAM read", $time);
    end

  // ready only for an i/o read or in the cycle after a RAM read
  assert property (@(posedge clk) disable iff (!rst_n)
                   !(rd && io_addr) && !$past(ram_rd) |-> !data_out_ready)
    else begin
      error_count++;
      $error("ERROR %0t data_out_ready high with no read answer due", $time);
    end

  // held request so the registered word meets the current lane select
  assert property (@(posedge clk) disable iff (!rst_n)
                   ram_rd && $past(ram_rd) && $stable(address) && $stable(read_type.raw) |->
                   data_out == expected_load(shadow[address[7:2]], read_type, address[1:0]))
    else begin
      error_count++;
      $error("ERROR %0t RAM read at %h gave %h", $time, address, data_out);
    end

endmodule

// attach to every ramio instance
bind ramio ramio_properties props_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .enable         (enable),
  .address        (address),
  .read_type      (read_type),
  .write_type     (write_type),
  .data_in        (data_in),
  .data_out       (data_out),
  .data_out_ready (data_out_ready),
  .led            (led),
  .uart_tx        (uart_tx),
  .tx_busy        (tx_busy)
);

// ==== dv/ramio_tb.sv ====
// --------------------------------------------------------------------------
// testbench for ramio: clock, reset, client stimulus and UART loopback
// bound assertions do the checking, this module ends the run
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module ramio_tb
  import ramio_map_pkg::*;
  import ramio_uart_pkg::*;
();

  // whole run is about 350 cycles, mostly the UART frame
  localparam int cycle_limit = 2000;
  // partial write targets
  localparam logic [31:0] word_a = 32'h0000_0050;
  localparam logic [31:0] word_b = 32'h0000_0054;

  logic              clk;
  logic              rst_n;
  logic              enable;
  logic [addr_w-1:0] address;
  read_type_t        read_type;
  logic [1:0]        write_type;
  logic [data_w-1:0] data_in;
  logic [data_w-1:0] data_out;
  logic              data_out_ready;
  logic [3:0]        led;
  // tx looped straight back to rx
  logic              uart_line;
  integer            seed;
  int                cycles = 0;
  // distinct RAM indices, upper bits ignored by the decode
  logic [31:0] ram_addrs [8] = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0028,
                                 32'h0000_007c, 32'h0000_00fc, 32'h1234_5610,
                                 32'h8000_0040, 32'h0000_0e88};
  logic [2:0]  load_types [4] = '{3'b001, 3'b101, 3'b010, 3'b110};

  ramio ramio_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .address        (address),
    .read_type      (read_type),
    .write_type     (write_type),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (uart_line),
    .uart_rx        (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one client write, done at the next rising edge
  task automatic drive_write(input logic [31:0] addr, input logic [1:0] wt,
                             input logic [31:0] wdata);
    enable     = 1'b1;
    address    = addr;
    read_type  = 3'b000;
    write_type = wt;
    data_in    = wdata;
    @(negedge clk);
    enable     = 1'b0;
    write_type = 2'b00;
  endtask

  // read held for a number of cycles
  task automatic drive_read(input logic [31:0] addr, input logic [2:0] rt, input int hold);
    enable     = 1'b1;
    address    = addr;
    read_type  = rt;
    write_type = 2'b00;
    repeat (hold) @(negedge clk);
    enable    = 1'b0;
    read_type = 3'b000;
  endtask

  // keep reading a UART word until it turns empty or non-empty
  task automatic poll_read(input logic [31:0] addr, input logic want_empty);
    enable     = 1'b1;
    address    = addr;
    read_type  = {1'b0, size_word};
    write_type = 2'b00;
    do begin
      @(negedge clk);
    end while ((data_out == uart_empty) != want_empty);
    // two more edges, the consuming read and the one after it
    repeat (2) @(negedge clk);
    enable    = 1'b0;
    read_type = 3'b000;
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    seed       = 32'h6de3_15a3;
    rst_n      = 1'b0;
    enable     = 1'b0;
    address    = '0;
    read_type  = 3'b000;
    write_type = 2'b00;
    data_in    = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // reset values of the i/o words
    drive_read(addr_uart_in, {1'b0, size_word}, 2);
    drive_read(addr_uart_out, {1'b0, size_word}, 2);
    drive_read(addr_led, {1'b0, size_word}, 1);

    // full word round trip
    for (int i = 0; i < 8; i++) begin
      drive_write(ram_addrs[i], size_word, $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      drive_read(ram_addrs[i], {1'b0, size_word}, 2);
    end

    // bytes and half words at every offset, odd half offsets included
    drive_write(word_a, size_word, $random(seed));
    drive_write(word_b, size_word, $random(seed));
    for (int off = 0; off < 4; off++) begin
      drive_write(word_a + off, size_byte, $random(seed));
      drive_write(word_b + off, size_half, $random(seed));
    end
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 4; k++) begin
        drive_read(word_a + off, load_types[k], 2);
        drive_read(word_b + off, load_types[k], 2);
      end
    end

    // LEDs hold between writes
    drive_write(addr_led, size_word, $random(seed));
    drive_read(word_a, {1'b0, size_word}, 3);
    drive_write(addr_led, size_word, $random(seed));
    repeat (2) @(negedge clk);

    // UART loopback, watch tx word while busy, then the echo
    drive_write(addr_uart_out, size_byte, $random(seed));
    drive_read(addr_uart_out, {1'b0, size_word}, 24);
    poll_read(addr_uart_in, 1'b0);
    poll_read(addr_uart_out, 1'b1);
    repeat (2) @(negedge clk);

    if (ramio_i.props_i.error_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "assertion errors at the end of the run");
    end
  end

  // stop at the first assertion failure
  always @(negedge clk) begin
    if (ramio_i.props_i.error_count != 0) begin
      $display("Checks failed");
      $fatal(1, "an assertion failed, see the ERROR line above");
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Checks failed");
      $fatal(1, "timeout: UART byte never came back within %0d cycles", cycle_limit);
    end
  end

endmodule

// ==== flist.f ====
src/ramio_map_pkg.sv
src/ramio_uart_pkg.sv
src/ramio_ctrl.sv
src/store_lanes.sv
src/load_extract.sv
src/word_ram.sv
src/uart_tx.sv
src/uart_rx.sv
src/ramio.sv
dv/ramio_properties.sv
dv/ramio_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the ramio testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module ramio_tb \
  -f flist.f -o ramio_sim > build.log 2>&1 \
  && ./obj_dir/ramio_sim +verilator+error+limit+100 > sim.log 2>&1
cat build.log sim.log 2>/dev/null
[ -f sim.log ] || { echo "build failed, no simulation log"; exit 1; }
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log && exit 0 || exit 1

// ==== src/load_extract.sv ====
// --------------------------------------------------------------------------
// picks the addressed lane out of a RAM word and extends it to 32 bits
// with sign or zeros as the read type asks
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module load_extract
  import ramio_map_pkg::*;
(
  input  read_type_t        read_type,
  input  logic [1:0]        addr_low,
  input  logic [data_w-1:0] ram_word,
  output logic [data_w-1:0] load_data
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;
  logic        sign_bit;

  // candidate lanes
  assign byte_lane = ram_word[{addr_low, 3'b000} +: 8];
  assign half_lane = ram_word[{addr_low[1], 4'b0000} +: 16];

  always_comb begin
    sign_bit  = 1'b0;
    load_data = '0;
    case (read_type.fields.size)
      size_byte: begin
        sign_bit  = read_type.fields.sign_ext && byte_lane[7];
        load_data = {{24{sign_bit}}, byte_lane};
      end
      size_half: begin
        sign_bit = read_type.fields.sign_ext && half_lane[15];
        // misaligned half word stays zero
        if (!addr_low[0]) begin
          load_data = {{16{sign_bit}}, half_lane};
        end
      end
      size_word: begin
        load_data = ram_word;
      end
      default: begin
        load_data = '0;
      end
    endcase
  end

endmodule

// ==== src/ramio.sv ====
// --------------------------------------------------------------------------
// ramio top level
// client port to word RAM, LED register and UART
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module ramio
  import ramio_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic [addr_w-1:0] address,
  input  read_type_t        read_type,
  input  logic [1:0]        write_type,
  input  logic [data_w-1:0] data_in,
  output logic [data_w-1:0] data_out,
  output logic              data_out_ready,
  output logic [3:0]        led,
  output logic              uart_tx,
  input  logic              uart_rx
);

  logic                   ram_en;
  logic                   ram_we;
  logic [ram_index_w-1:0] ram_index;
  logic                   ram_read_pending;
  logic                   io_read_hit;
  logic [data_w-1:0]      io_data;
  logic [data_w-1:0]      lane_data;
  logic [3:0]             byte_en;
  logic [data_w-1:0]      ram_word;
  logic [data_w-1:0]      load_data;
  logic                   tx_go;
  logic [7:0]             tx_byte;
  logic                   tx_busy;
  logic                   rx_go;
  logic                   rx_ready;
  logic [7:0]             rx_byte;

  ramio_ctrl ctrl_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .enable           (enable),
    .address          (address),
    .read_type        (read_type),
    .write_type       (write_type),
    .data_in          (data_in),
    .ram_en           (ram_en),
    .ram_we           (ram_we),
    .ram_index        (ram_index),
    .ram_read_pending (ram_read_pending),
    .io_read_hit      (io_read_hit),
    .io_data          (io_data),
    .led              (led),
    .tx_go            (tx_go),
    .tx_byte          (tx_byte),
    .rx_go            (rx_go),
    .tx_busy          (tx_busy),
    .rx_ready         (rx_ready),
    .rx_byte          (rx_byte)
  );

  store_lanes lanes_i (
    .write_type (write_type),
    .addr_low   (address[1:0]),
    .data_in    (data_in),
    .lane_data  (lane_data),
    .byte_en    (byte_en)
  );

  // lanes only written for a RAM write
  word_ram ram_i (
    .clk     (clk),
    .en      (ram_en),
    .byte_en (ram_we ? byte_en : 4'b0000),
    .index   (ram_index),
    .wdata   (lane_data),
    .rdata   (ram_word)
  );

  load_extract extract_i (
    .read_type (read_type),
    .addr_low  (address[1:0]),
    .ram_word  (ram_word),
    .load_data (load_data)
  );

  uart_tx tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (tx_byte),
    .tx    (uart_tx),
    .busy  (tx_busy)
  );

  uart_rx rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_byte),
    .data_ready (rx_ready)
  );

  // i/o answers now, RAM one cycle later
  assign data_out_ready = io_read_hit || ram_read_pending;
  assign data_out       = io_read_hit ? io_data : load_data;

endmodule

// ==== src/ramio_ctrl.sv ====
// --------------------------------------------------------------------------
// address decode and steering between the word RAM and the i/o words
// owns the LED register, the UART holding words and the RAM read flag
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module ramio_ctrl
  import ramio_map_pkg::*;
  import ramio_uart_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable,
  input  logic [addr_w-1:0]      address,
  input  read_type_t             read_type,
  input  logic [1:0]             write_type,
  input  logic [data_w-1:0]      data_in,
  output logic                   ram_en,
  output logic                   ram_we,
  output logic [ram_index_w-1:0] ram_index,
  output logic                   ram_read_pending,
  output logic                   io_read_hit,
  output logic [data_w-1:0]      io_data,
  output logic [3:0]             led,
  output logic                   tx_go,
  output logic [7:0]             tx_byte,
  output logic                   rx_go,
  input  logic                   tx_busy,
  input  logic                   rx_ready,
  input  logic [7:0]             rx_byte
);

  logic              hit_led;
  logic              hit_tx;
  logic              hit_rx;
  logic              hit_io;
  logic              do_read;
  logic              do_write;
  logic [data_w-1:0] tx_word;
  logic [data_w-1:0] rx_word;
  // holding word not yet taken by the transmitter
  logic              tx_pending;
  logic              tx_busy_q;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  // one compare per i/o word
  assign hit_led = (address == addr_led);
  assign hit_tx  = (address == addr_uart_out);
  assign hit_rx  = (address == addr_uart_in);
  assign hit_io  = hit_led || hit_tx || hit_rx;

  assign do_read  = enable && (read_type.raw != 3'b000);
  assign do_write = enable && (write_type != 2'b00);

  // everything outside the i/o words lands in RAM
  assign ram_en    = (do_read || do_write) && !hit_io;
  assign ram_we    = do_write && !hit_io;
  assign ram_index = address[ram_index_w+1:2];

  // i/o reads answer in the same cycle
  assign io_read_hit = do_read && hit_io;
  assign tx_byte     = tx_word[7:0];

  always_comb begin
    io_data = '0;
    // LED register reads as zero
    if (hit_tx) begin
      io_data = tx_word;
    end else if (hit_rx) begin
      io_data = rx_word;
    end
  end

  // RAM read data shows up one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_read_pending <= 1'b0;
    end else begin
      ram_read_pending <= do_read && !hit_io;
    end
  end

  // a one turns the LED off
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= 4'b1111;
    end else if (do_write && hit_led) begin
      led <= data_in[3:0];
    end
  end

  // --------------------------------------------------------------------------
  // uart transmit word
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_go      <= 1'b0;
      tx_pending <= 1'b0;
      tx_busy_q  <= 1'b0;
      tx_word    <= uart_empty;
    end else begin
      tx_busy_q <= tx_busy;
      // busy rising means the byte was taken
      if (tx_busy && !tx_busy_q) begin
        tx_pending <= 1'b0;
      end
      // byte sent and nothing newer waiting
      if (tx_go && !tx_busy && !tx_pending) begin
        tx_go   <= 1'b0;
        tx_word <= uart_empty;
      end
      // a later write replaces the word and is sent next
      if (do_write && hit_tx) begin
        tx_word    <= {24'h00_0000, data_in[7:0]};
        tx_go      <= 1'b1;
        tx_pending <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // uart receive word
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_go   <= 1'b1;
      rx_word <= uart_empty;
    end else begin
      // consumed by the read
      if (do_read && hit_rx) begin
        rx_word <= uart_empty;
      end
      // copy new byte, drop go one cycle as ack
      // overrun just overwrites
      if (rx_go && rx_ready) begin
        rx_word <= {24'h00_0000, rx_byte};
        rx_go   <= 1'b0;
      end else begin
        rx_go <= 1'b1;
      end
    end
  end

endmodule

// ==== src/ramio_map_pkg.sv ====
// --------------------------------------------------------------------------
// address map and access encodings of the ramio front end
// shared by the control, lane and RAM blocks and by the checkers
// --------------------------------------------------------------------------
package ramio_map_pkg;

  // client bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // on-chip word RAM
  localparam int ram_words = 64;
  localparam int ram_index_w = 6;

  // i/o words at the top of the address space
  localparam logic [addr_w-1:0] addr_led      = 32'hffff_fffc;
  localparam logic [addr_w-1:0] addr_uart_out = 32'hffff_fff8;
  localparam logic [addr_w-1:0] addr_uart_in  = 32'hffff_fff4;

  // size codes, read type low bits and write type alike
  localparam logic [1:0] size_byte = 2'b01;
  localparam logic [1:0] size_half = 2'b10;
  localparam logic [1:0] size_word = 2'b11;

  // read type split into sign flag and size
  typedef struct packed {
    logic       sign_ext;
    logic [1:0] size;
  } read_fields_t;

  // all zero raw code means no read
  typedef union packed {
    logic [2:0]   raw;
    read_fields_t fields;
  } read_type_t;

endpackage

// ==== src/ramio_uart_pkg.sv ====
// --------------------------------------------------------------------------
// UART bit timing and the word value that marks an idle or empty UART
// --------------------------------------------------------------------------
package ramio_uart_pkg;

  // clocks per bit, short so simulation stays quick
  localparam int clks_per_bit = 16;

  // bit period counter width and its compare points
  localparam int clk_cnt_w = $clog2(clks_per_bit);
  localparam logic [clk_cnt_w-1:0] clk_last = clk_cnt_w'(clks_per_bit - 1);
  localparam logic [clk_cnt_w-1:0] clk_half = clk_cnt_w'(clks_per_bit / 2 - 1);

  // idle transmitter or nothing received
  localparam logic [31:0] uart_empty = 32'hffff_ffff;

endpackage

// ==== src/store_lanes.sv ====
// --------------------------------------------------------------------------
// moves a byte, half word or word onto its RAM byte lanes
// and builds the matching byte enables
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module store_lanes
  import ramio_map_pkg::*;
(
  input  logic [1:0]        write_type,
  input  logic [1:0]        addr_low,
  input  logic [data_w-1:0] data_in,
  output logic [data_w-1:0] lane_data,
  output logic [3:0]        byte_en
);

  always_comb begin
    lane_data = '0;
    byte_en   = 4'b0000;
    case (write_type)
      size_byte: begin
        // one lane picked by the low address bits
        byte_en   = 4'b0001 << addr_low;
        lane_data = {24'h00_0000, data_in[7:0]} << {addr_low, 3'b000};
      end
      size_half: begin
        // only offsets 0 and 2
        if (!addr_low[0]) begin
          byte_en   = addr_low[1] ? 4'b1100 : 4'b0011;
          lane_data = {16'h0000, data_in[15:0]} << {addr_low[1], 4'b0000};
        end
      end
      size_word: begin
        byte_en   = 4'b1111;
        lane_data = data_in;
      end
      // not a write
      default: begin
        byte_en = 4'b0000;
      end
    endcase
  end

endmodule

// ==== src/uart_rx.sv ====
// --------------------------------------------------------------------------
// 8N1 receiver
// data_ready rises after a good stop bit and holds until go drops
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module uart_rx
  import ramio_uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  // two sync flops plus one for the edge
  logic [2:0]           rx_sync;
  logic                 rx_s;
  logic                 fall;
  logic                 active;
  logic                 tick;
  logic [3:0]           bit_cnt;
  logic [clk_cnt_w-1:0] clk_cnt;

  assign rx_s = rx_sync[1];
  assign fall = rx_sync[2] && !rx_sync[1];

  // half a bit into the start bit, full bits after that
  assign tick = (bit_cnt == 4'd0) ? (clk_cnt == clk_half) : (clk_cnt == clk_last);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_sync    <= 3'b111;
      active     <= 1'b0;
      bit_cnt    <= '0;
      clk_cnt    <= '0;
      data_ready <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
      // ack from the owner
      if (!go) begin
        data_ready <= 1'b0;
      end
      if (!active) begin
        if (fall) begin
          active  <= 1'b1;
          bit_cnt <= '0;
          clk_cnt <= '0;
        end
      end else if (!tick) begin
        clk_cnt <= clk_cnt + 1'b1;
      end else begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 4'd1;
        // line back high mid start bit so no frame
        if (bit_cnt == 4'd0 && rx_s) begin
          active <= 1'b0;
        end
        // stop bit sample
        if (bit_cnt == 4'd9) begin
          active <= 1'b0;
          if (rx_s) begin
            data_ready <= 1'b1;
          end
        end
      end
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (active && tick && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
      data <= {rx_s, data[7:1]};
    end
  end

endmodule

// ==== src/uart_tx.sv ====
// --------------------------------------------------------------------------
// 8N1 transmitter
// takes data when go is high and idle, busy while the frame is on the line
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module uart_tx
  import ramio_uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic [7:0] data,
  output logic       tx,
  output logic       busy
);

  // stop, data lsb first, start
  logic [9:0]           frame;
  logic [3:0]           bit_cnt;
  logic [clk_cnt_w-1:0] clk_cnt;
  // one quiet cycle after the stop bit so go can drop
  logic                 done;
  logic                 start;

  assign start = go && !busy && !done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      bit_cnt <= '0;
      clk_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        clk_cnt <= '0;
      end else if (busy) begin
        if (clk_cnt == clk_last) begin
          clk_cnt <= '0;
          // end of stop bit
          if (bit_cnt == 4'd9) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      frame <= {1'b1, data, 1'b0};
    end
  end

  // line idles high
  assign tx = busy ? frame[bit_cnt] : 1'b1;

endmodule

// ==== src/word_ram.sv ====
// --------------------------------------------------------------------------
// 64 word on-chip RAM with per-byte write enables and registered read
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module word_ram
  import ramio_map_pkg::*;
(
  input  logic                   clk,
  input  logic                   en,
  input  logic [3:0]             byte_en,
  input  logic [ram_index_w-1:0] index,
  input  logic [data_w-1:0]      wdata,
  output logic [data_w-1:0]      rdata
);

  // four byte lanes per word
  logic [3:0][7:0] mem [ram_words];

  always_ff @(posedge clk) begin
    if (en) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byte_en[lane]) begin
          mem[index][lane] <= wdata[8*lane +: 8];
        end
      end
      // old contents on a same-cycle write
      rdata <= mem[index];
    end
  end

endmodule
